// File: filelist.f
+incdir+rtl
+incdir+tb
rtl/fpu_pkg.sv
rtl/fpu_if.sv
rtl/fpu_unpack.sv
rtl/fpu_mul.sv
rtl/fpu_rnd.sv
rtl/fpu_mul_top.sv
tb/tb_fpu_mul_top.sv

// File: rtl/fpu_defines.svh
// width and format constants for the fp multiplier
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// signed working exponent, wide enough for out-of-range products
`define FPU_EXP_W   14

// working significand, hidden bit plus one rounding carry bit
`define FPU_MANT_W  54

`define FPU_FLAGS_W 5   // nv, dz, of, uf, nx

// largest finite biased exponents
`define FPU_SP_EMAX 254
`define FPU_DP_EMAX 2046

`define FPU_SP_BIAS 127
`define FPU_DP_BIAS 1023

`endif

// File: rtl/fpu_if.sv
// stage interfaces: unpack to multiply, multiply to round
`default_nettype none
`include "fpu_defines.svh"

interface unp_if
    import fpu_pkg::*;
();
    logic                         valid;
    fmt_e                         fmt;
    rm_e                          rm;
    logic                         sig_a;
    logic signed [`FPU_EXP_W-1:0] expo_a;   // biased, may go below one for subnormals
    logic [`FPU_MANT_W-2:0]       mant_a;   // hidden bit at 52 in both formats
    logic                         sig_b;
    logic signed [`FPU_EXP_W-1:0] expo_b;
    logic [`FPU_MANT_W-2:0]       mant_b;
    logic                         nv;       // invalid operation
    logic                         qnan;
    logic                         infs;
    logic                         zero;

    modport src (output valid, fmt, rm, sig_a, expo_a, mant_a, sig_b, expo_b, mant_b,
                 output nv, qnan, infs, zero);
    modport dst (input valid, fmt, rm, sig_a, expo_a, mant_a, sig_b, expo_b, mant_b,
                 input nv, qnan, infs, zero);
endinterface

interface rnd_if
    import fpu_pkg::*;
();
    logic                    valid;
    logic                    sig;
    logic [`FPU_EXP_W-1:0]   expo;   // zero means subnormal range
    logic [`FPU_MANT_W-1:0]  mant;   // hidden bit at 23 or 52
    logic [2:0]              grs;
    fmt_e                    fmt;
    rm_e                     rm;
    logic                    snan;   // NaN from an invalid operation
    logic                    qnan;
    logic                    infs;
    logic                    zero;

    modport src (output valid, sig, expo, mant, grs, fmt, rm, snan, qnan, infs, zero);
    modport dst (input valid, sig, expo, mant, grs, fmt, rm, snan, qnan, infs, zero);
endinterface

`default_nettype wire

// File: rtl/fpu_mul.sv
// significand product, exponent sum, normalisation and grs extraction
`default_nettype none
`include "fpu_defines.svh"

module fpu_mul
    import fpu_pkg::*;
(
    input  wire clk,
    input  wire rst_n,
    unp_if.dst  unp_i,
    rnd_if.src  rnd_o
);

    logic [105:0]                 prod;
    logic [105:0]                 norm;
    logic                         hi;
    logic signed [`FPU_EXP_W-1:0] bias;
    logic signed [`FPU_EXP_W-1:0] expo_p;
    logic signed [`FPU_EXP_W-1:0] sh_s;
    logic [6:0]                   sh;
    logic [105:0]                 shifted;
    logic                         lost;
    logic [`FPU_EXP_W-1:0]        expo_n;
    logic [`FPU_MANT_W-1:0]       mant_n;
    logic [2:0]                   grs_n;

    // both significands in [1,2), product in [1,4)
    assign prod = unp_i.mant_a * unp_i.mant_b;

    always_comb begin
        hi   = prod[105];
        norm = hi ? prod : {prod[104:0], 1'b0};   // leading one at bit 105
        if (unp_i.fmt == FMT_DP) begin
            bias = `FPU_EXP_W'(`FPU_DP_BIAS);
        end else begin
            bias = `FPU_EXP_W'(`FPU_SP_BIAS);
        end
        expo_p = unp_i.expo_a + unp_i.expo_b - bias + `FPU_EXP_W'(hi);
        sh_s   = `FPU_EXP_W'(1) - expo_p;

        // tiny product: denormalise, exponent field becomes zero
        if (expo_p <= 0) begin
            sh     = (sh_s > 106) ? 7'd106 : sh_s[6:0];
            expo_n = '0;
        end else begin
            sh     = 7'd0;
            expo_n = expo_p;   // may exceed emax, round stage saturates
        end
        shifted = norm >> sh;
        lost    = |(norm & ~({106{1'b1}} << sh));   // bits dropped by the shift

        if (unp_i.fmt == FMT_DP) begin
            mant_n = {1'b0, shifted[105:53]};
            grs_n  = {shifted[52], shifted[51], (|shifted[50:0]) | lost};
        end else begin
            mant_n = {30'h0, shifted[105:82]};
            grs_n  = {shifted[81], shifted[80], (|shifted[79:0]) | lost};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rnd_o.valid <= 1'b0;
            rnd_o.sig   <= 1'b0;
            rnd_o.expo  <= '0;
            rnd_o.mant  <= '0;
            rnd_o.grs   <= 3'b000;
            rnd_o.fmt   <= FMT_SP;
            rnd_o.rm    <= RM_RNE;
            rnd_o.snan  <= 1'b0;
            rnd_o.qnan  <= 1'b0;
            rnd_o.infs  <= 1'b0;
            rnd_o.zero  <= 1'b0;
        end else begin
            rnd_o.valid <= unp_i.valid;
            rnd_o.sig   <= unp_i.sig_a ^ unp_i.sig_b;
            rnd_o.expo  <= expo_n;
            rnd_o.mant  <= mant_n;
            rnd_o.grs   <= grs_n;
            rnd_o.fmt   <= unp_i.fmt;
            rnd_o.rm    <= unp_i.rm;
            rnd_o.snan  <= unp_i.nv;   // invalid gives the signalling class
            rnd_o.qnan  <= unp_i.qnan;
            rnd_o.infs  <= unp_i.infs;
            rnd_o.zero  <= unp_i.zero;
        end
    end

endmodule

`default_nettype wire

// File: rtl/fpu_mul_top.sv
// fp multiplier top level joining the unpack, multiply and round stages
`default_nettype none
`include "fpu_defines.svh"

module fpu_mul_top
    import fpu_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     valid_i,
    input  wire                     fmt_i,     // 0 single, 1 double
    input  wire [2:0]               rm_i,      // rne, rtz, rdn, rup, rmm
    input  wire [63:0]              op_a_i,
    input  wire [63:0]              op_b_i,
    output logic                    valid_o,
    output logic [63:0]             result_o,
    output logic [`FPU_FLAGS_W-1:0] flags_o
);

    unp_if unp ();
    rnd_if rnd ();

    fpu_unpack u_unpack (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_i (valid_i),
        .fmt_i   (fmt_e'(fmt_i)),
        .rm_i    (rm_e'(rm_i)),
        .op_a_i  (fp_word_u'(op_a_i)),
        .op_b_i  (fp_word_u'(op_b_i)),
        .unp_o   (unp.src)
    );

    fpu_mul u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .unp_i (unp.dst),
        .rnd_o (rnd.src)
    );

    fpu_rnd u_rnd (
        .clk      (clk),
        .rst_n    (rst_n),
        .rnd_i    (rnd.dst),
        .valid_o  (valid_o),
        .result_o (result_o),
        .flags_o  (flags_o)
    );

endmodule

`default_nettype wire

// File: rtl/fpu_pkg.sv
// fp multiplier types: operand word union, format and rounding-mode enums
`default_nettype none

package fpu_pkg;

    typedef enum logic {
        FMT_SP = 1'b0,
        FMT_DP = 1'b1
    } fmt_e;

    typedef enum logic [2:0] {
        RM_RNE = 3'd0,   // nearest, ties to even
        RM_RTZ = 3'd1,
        RM_RDN = 3'd2,   // toward -inf
        RM_RUP = 3'd3,   // toward +inf
        RM_RMM = 3'd4    // nearest, ties away
    } rm_e;

    // one operand word, read as binary64 or as binary32 in the low half
    typedef union packed {
        struct packed {
            logic        sign;
            logic [10:0] exp;
            logic [51:0] frac;
        } f64;
        struct packed {
            logic [31:0] unused;   // upper half, ignored for single
            logic        sign;
            logic [7:0]  exp;
            logic [22:0] frac;
        } f32;
    } fp_word_u;

endpackage

`default_nettype wire

// File: rtl/fpu_rnd.sv
// rounding, exception flags and result packing stage
`default_nettype none
`include "fpu_defines.svh"

module fpu_rnd
    import fpu_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n,
    rnd_if.dst                      rnd_i,
    output logic                    valid_o,
    output logic [63:0]             result_o,
    output logic [`FPU_FLAGS_W-1:0] flags_o
);

    logic                    valid_r;
    logic                    sig_r;
    logic [`FPU_EXP_W-1:0]   expo_r;
    logic [`FPU_MANT_W-1:0]  mant_r;
    logic [2:0]              grs_r;
    fmt_e                    fmt_r;
    rm_e                     rm_r;
    logic                    snan_r;
    logic                    qnan_r;
    logic                    infs_r;
    logic                    zero_r;

    logic [`FPU_EXP_W-1:0]   expo;
    logic [`FPU_MANT_W-1:0]  mant;
    logic                    inexact;
    logic                    odd;
    logic                    rndup;
    logic                    rnddn;
    logic                    shift;
    logic                    min_norm;
    logic [63:0]             result;
    logic [`FPU_FLAGS_W-1:0] flags;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
            sig_r   <= 1'b0;
            expo_r  <= '0;
            mant_r  <= '0;
            grs_r   <= 3'b000;
            fmt_r   <= FMT_SP;
            rm_r    <= RM_RNE;
            snan_r  <= 1'b0;
            qnan_r  <= 1'b0;
            infs_r  <= 1'b0;
            zero_r  <= 1'b0;
        end else begin
            valid_r <= rnd_i.valid;
            sig_r   <= rnd_i.sig;
            expo_r  <= rnd_i.expo;
            mant_r  <= rnd_i.mant;
            grs_r   <= rnd_i.grs;
            fmt_r   <= rnd_i.fmt;
            rm_r    <= rnd_i.rm;
            snan_r  <= rnd_i.snan;
            qnan_r  <= rnd_i.qnan;
            infs_r  <= rnd_i.infs;
            zero_r  <= rnd_i.zero;
        end
    end

    always_comb begin
        expo     = expo_r;
        result   = '0;
        flags    = '0;
        inexact  = |grs_r;
        flags[0] = inexact;
        odd      = mant_r[0] | (|grs_r[1:0]);   // tie breaks up only on odd lsb

        rndup = 1'b0;
        rnddn = 1'b0;
        case (rm_r)
            RM_RNE: rndup = grs_r[2] & odd;
            RM_RTZ: rnddn = 1'b1;
            RM_RDN: begin
                rndup = sig_r & inexact;
                rnddn = ~sig_r;
            end
            RM_RUP: begin
                rndup = ~sig_r & inexact;
                rnddn = sig_r;
            end
            RM_RMM: rndup = grs_r[2];
            default: rndup = 1'b0;
        endcase

        mant = mant_r + `FPU_MANT_W'(rndup);

        // subnormal rounded up into the smallest normal
        if (rndup && expo_r == '0) begin
            if ((fmt_r == FMT_SP && mant[23]) || (fmt_r == FMT_DP && mant[52])) begin
                expo = `FPU_EXP_W'(1);
            end
        end

        // modes rounding toward zero for this sign saturate on overflow
        if (rnddn) begin
            if (fmt_r == FMT_SP && $signed(expo) > `FPU_SP_EMAX) begin
                expo  = `FPU_EXP_W'(`FPU_SP_EMAX);
                mant  = {31'h0, {23{1'b1}}};
                flags = 5'b00101;
            end else if (fmt_r == FMT_DP && $signed(expo) > `FPU_DP_EMAX) begin
                expo  = `FPU_EXP_W'(`FPU_DP_EMAX);
                mant  = {2'b00, {52{1'b1}}};
                flags = 5'b00101;
            end
        end

        shift = (fmt_r == FMT_SP) ? mant[24] : mant[53];   // carry out of rounding
        expo  = expo + `FPU_EXP_W'(shift);
        mant  = mant >> shift;

        if (expo == '0) begin
            flags[1] = flags[0];   // tiny and inexact
        end

        // exactly smallest normal after rounding up, tiny with unbounded exponent?
        if (fmt_r == FMT_SP) begin
            min_norm = (mant[22:0] == '0);
        end else begin
            min_norm = (mant[51:0] == '0);
        end
        if (rndup && expo == `FPU_EXP_W'(1) && min_norm) begin
            if (rm_r == RM_RDN || rm_r == RM_RUP) begin
                flags[1] = ~grs_r[2] | ~(|grs_r[1:0]);
            end else begin
                flags[1] = grs_r[2] & ~grs_r[1];
            end
        end

        // special classes override the computed flags
        if (snan_r) begin
            flags = 5'b10000;
        end else if (qnan_r || infs_r || zero_r) begin
            flags = 5'b00000;
        end

        if (fmt_r == FMT_SP) begin
            if (snan_r || qnan_r) begin
                result = {32'h0, 1'b0, 8'hff, 23'h400000};   // canonical qnan
            end else if (infs_r) begin
                result = {32'h0, sig_r, 8'hff, 23'h0};
            end else if (zero_r) begin
                result = {32'h0, sig_r, 8'h00, 23'h0};
            end else if (expo == '0) begin
                result = {32'h0, sig_r, 8'h00, mant[22:0]};
            end else if ($signed(expo) > `FPU_SP_EMAX) begin
                flags  = 5'b00101;
                result = {32'h0, sig_r, 8'hff, 23'h0};
            end else begin
                result = {32'h0, sig_r, expo[7:0], mant[22:0]};
            end
        end else begin
            if (snan_r || qnan_r) begin
                result = {1'b0, 11'h7ff, 52'h8_0000_0000_0000};
            end else if (infs_r) begin
                result = {sig_r, 11'h7ff, 52'h0};
            end else if (zero_r) begin
                result = {sig_r, 11'h000, 52'h0};
            end else if (expo == '0) begin
                result = {sig_r, 11'h000, mant[51:0]};
            end else if ($signed(expo) > `FPU_DP_EMAX) begin
                flags  = 5'b00101;
                result = {sig_r, 11'h7ff, 52'h0};
            end else begin
                result = {sig_r, expo[10:0], mant[51:0]};
            end
        end
    end

    assign valid_o  = valid_r;
    assign result_o = result;
    assign flags_o  = flags;

endmodule

`default_nettype wire

// File: rtl/fpu_unpack.sv
// operand decode, special-value classification and subnormal normalisation
`default_nettype none
`include "fpu_defines.svh"

module fpu_unpack
    import fpu_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire           valid_i,
    input  wire fmt_e     fmt_i,
    input  wire rm_e      rm_i,
    input  wire fp_word_u op_a_i,
    input  wire fp_word_u op_b_i,
    unp_if.src            unp_o
);

    logic                         sig_a;
    logic signed [`FPU_EXP_W-1:0] expo_a;
    logic [`FPU_MANT_W-2:0]       mant_a;
    logic                         nan_a;
    logic                         snan_a;
    logic                         inf_a;
    logic                         zero_a;
    logic                         sig_b;
    logic signed [`FPU_EXP_W-1:0] expo_b;
    logic [`FPU_MANT_W-2:0]       mant_b;
    logic                         nan_b;
    logic                         snan_b;
    logic                         inf_b;
    logic                         zero_b;
    logic                         nv;
    logic                         qnan;
    logic                         infs;
    logic                         zero;

    // single fraction is left aligned to the double position
    function automatic void decode(
        input  fp_word_u                     w,
        input  fmt_e                         fmt,
        output logic                         sig,
        output logic signed [`FPU_EXP_W-1:0] expo,
        output logic [`FPU_MANT_W-2:0]       mant,
        output logic                         is_nan,
        output logic                         is_snan,
        output logic                         is_inf,
        output logic                         is_zero
    );
        logic [10:0] e;
        logic [51:0] f;
        logic        e_ones;
        logic [5:0]  lz;

        if (fmt == FMT_DP) begin
            sig    = w.f64.sign;
            e      = w.f64.exp;
            f      = w.f64.frac;
            e_ones = &w.f64.exp;
        end else begin
            sig    = w.f32.sign;
            e      = {3'b000, w.f32.exp};
            f      = {w.f32.frac, 29'h0};
            e_ones = &w.f32.exp;
        end
        is_zero = (e == '0) && (f == '0);
        is_inf  = e_ones && (f == '0);
        is_nan  = e_ones && (f != '0);
        is_snan = is_nan && !f[51];   // quiet bit is the fraction msb

        lz = 6'd51;
        for (int i = 0; i < 52; i++) begin
            if (f[i]) begin
                lz = 6'(51 - i);
            end
        end

        if (e == '0) begin   // subnormal, move leading one up to bit 52
            mant = {1'b0, f} << (lz + 6'd1);
            expo = -`FPU_EXP_W'(lz);
        end else begin
            mant = {1'b1, f};
            expo = `FPU_EXP_W'(e);
        end
    endfunction

    always_comb begin
        decode(op_a_i, fmt_i, sig_a, expo_a, mant_a, nan_a, snan_a, inf_a, zero_a);
        decode(op_b_i, fmt_i, sig_b, expo_b, mant_b, nan_b, snan_b, inf_b, zero_b);

        // class of the product
        nv   = snan_a | snan_b | (inf_a & zero_b) | (zero_a & inf_b);
        qnan = ~nv & (nan_a | nan_b);
        infs = ~nv & ~nan_a & ~nan_b & (inf_a | inf_b);
        zero = ~nv & ~nan_a & ~nan_b & ~inf_a & ~inf_b & (zero_a | zero_b);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unp_o.valid  <= 1'b0;
            unp_o.fmt    <= FMT_SP;
            unp_o.rm     <= RM_RNE;
            unp_o.sig_a  <= 1'b0;
            unp_o.expo_a <= '0;
            unp_o.mant_a <= '0;
            unp_o.sig_b  <= 1'b0;
            unp_o.expo_b <= '0;
            unp_o.mant_b <= '0;
            unp_o.nv     <= 1'b0;
            unp_o.qnan   <= 1'b0;
            unp_o.infs   <= 1'b0;
            unp_o.zero   <= 1'b0;
        end else begin
            unp_o.valid  <= valid_i;
            unp_o.fmt    <= fmt_i;
            unp_o.rm     <= rm_i;
            unp_o.sig_a  <= sig_a;
            unp_o.expo_a <= expo_a;
            unp_o.mant_a <= mant_a;
            unp_o.sig_b  <= sig_b;
            unp_o.expo_b <= expo_b;
            unp_o.mant_b <= mant_b;
            unp_o.nv     <= nv;
            unp_o.qnan   <= qnan;
            unp_o.infs   <= infs;
            unp_o.zero   <= zero;
        end
    end

endmodule

`default_nettype wire

// File: tb/fpu_model.svh
// reference multiply model, lcg and operand generators for the testbench
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

`include "fpu_defines.svh"

localparam logic [31:0] LCG_SEED = 32'h850c_5cac;

logic [31:0] lcg_state = LCG_SEED;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// keeps p >> s and rounds the dropped bits by mode, nx when anything is dropped
function automatic logic [127:0] round_at(input logic [127:0] p, input int s, input logic sgn,
                                          input logic [2:0] rm, output logic nx);
    int           sh;
    logic [127:0] kept;
    logic [127:0] rem;
    logic [127:0] half;
    logic         up;
    if (s <= 0) begin
        nx = 1'b0;
        return p << (-s);
    end
    sh   = (s > 120) ? 120 : s;   // product is far narrower than 120 bits
    kept = p >> sh;
    half = 128'd1 << (sh - 1);
    rem  = p & ((128'd1 << sh) - 128'd1);
    nx   = (rem != 0);
    case (rm)
        3'd0:    up = (rem > half) || (rem == half && kept[0]);   // ties to even
        3'd1:    up = 1'b0;
        3'd2:    up = sgn && nx;
        3'd3:    up = !sgn && nx;
        default: up = (rem >= half);                              // ties away
    endcase
    return kept + 128'(up);
endfunction

// expected {flags, result} of a * b, exact integer product then one rounding
function automatic logic [68:0] model_mul(input logic [63:0] a, input logic [63:0] b,
                                          input logic dp, input logic [2:0] rm);
    int           fw;
    int           bias;
    int           emax;
    int           xa;
    int           xb;
    int           n;
    int           e;
    int           q;
    int           ex;
    logic [51:0]  fa;
    logic [51:0]  fb;
    logic         sg;
    logic         nan_a, nan_b, snan_a, snan_b, inf_a, inf_b, zero_a, zero_b;
    logic         nx;
    logic         tiny;
    logic [63:0]  qnan;
    logic [63:0]  inf_w;
    logic [63:0]  max_w;
    logic [127:0] p;
    logic [127:0] m;
    fw     = dp ? 52 : 23;
    bias   = dp ? `FPU_DP_BIAS : `FPU_SP_BIAS;
    emax   = dp ? `FPU_DP_EMAX : `FPU_SP_EMAX;
    sg     = dp ? a[63] ^ b[63] : a[31] ^ b[31];
    xa     = dp ? a[62:52] : a[30:23];
    xb     = dp ? b[62:52] : b[30:23];
    fa     = dp ? a[51:0] : 52'(a[22:0]);
    fb     = dp ? b[51:0] : 52'(b[22:0]);
    nan_a  = (xa == emax + 1) && (fa != 0);
    nan_b  = (xb == emax + 1) && (fb != 0);
    snan_a = nan_a && !fa[fw-1];
    snan_b = nan_b && !fb[fw-1];
    inf_a  = (xa == emax + 1) && (fa == 0);
    inf_b  = (xb == emax + 1) && (fb == 0);
    zero_a = (xa == 0) && (fa == 0);
    zero_b = (xb == 0) && (fb == 0);
    qnan   = dp ? 64'h7ff8_0000_0000_0000 : 64'h7fc0_0000;
    inf_w  = dp ? {sg, 11'h7ff, 52'h0} : {32'h0, sg, 8'hff, 23'h0};
    max_w  = dp ? {sg, 11'h7fe, {52{1'b1}}} : {32'h0, sg, 8'hfe, {23{1'b1}}};
    if (snan_a || snan_b || (inf_a && zero_b) || (zero_a && inf_b)) begin
        return {5'b10000, qnan};
    end else if (nan_a || nan_b) begin
        return {5'b00000, qnan};
    end else if (inf_a || inf_b) begin
        return {5'b00000, inf_w};
    end else if (zero_a || zero_b) begin
        return {5'b00000, dp ? {sg, 63'h0} : {32'h0, sg, 31'h0}};
    end

    // value of the exact product is p * 2^e
    p = ((xa == 0) ? 128'(fa) : 128'(fa) | (128'd1 << fw)) *
        ((xb == 0) ? 128'(fb) : 128'(fb) | (128'd1 << fw));
    e = ((xa == 0) ? 1 : xa) + ((xb == 0) ? 1 : xb) - 2 * bias - 2 * fw;
    n = 0;
    for (int i = 0; i < 128; i++) begin
        if (p[i]) begin
            n = i;
        end
    end

    m    = round_at(p, n - fw, sg, rm, nx);   // unbounded exponent, tininess only
    tiny = (n + e + bias + int'(m[fw+1])) < 1;

    q = (n + e + bias >= 1) ? n + e - fw : 1 - bias - fw;   // weight of the result lsb
    m = round_at(p, q - e, sg, rm, nx);
    if (m[fw+1]) begin
        m = m >> 1;
        q = q + 1;
    end
    if (m[fw]) begin
        ex    = q + fw + bias;
        m[fw] = 1'b0;
    end else begin
        ex = 0;
    end
    if (ex > emax) begin
        if (rm == 3'd1 || (rm == 3'd2 && !sg) || (rm == 3'd3 && sg)) begin
            return {5'b00101, max_w};
        end
        return {5'b00101, inf_w};
    end
    return {3'b000, tiny & nx, nx,
            dp ? {sg, 11'(ex), m[51:0]} : {32'h0, sg, 8'(ex), m[22:0]}};
endfunction

// one operand, mixing normals, range edges, subnormals and special values
function automatic logic [63:0] gen_operand(input logic dp);
    logic [31:0] r;
    logic [63:0] frac;
    int          fw;
    int          emax;
    int          bias;
    int          cat;
    int          x;
    r    = lcg_next();
    fw   = dp ? 52 : 23;
    emax = dp ? `FPU_DP_EMAX : `FPU_SP_EMAX;
    bias = dp ? `FPU_DP_BIAS : `FPU_SP_BIAS;
    cat  = r[30:26];
    frac = {lcg_next(), lcg_next()};
    if (r[25:24] == 2'b11) begin
        frac = ~(frac & 64'h3);   // nearly all ones, pushes rounding carries
    end
    frac = frac & ((64'd1 << fw) - 64'd1);
    if (cat < 9) begin
        x = 1 + int'(lcg_next() % emax);
    end else if (cat < 16) begin
        x = bias - 4 + int'(lcg_next() % 8);   // close to one
    end else if (cat < 20) begin
        x = emax - int'(lcg_next() % 8);
    end else if (cat < 25) begin
        x = 1 + int'(lcg_next() % 8);          // smallest normals
    end else if (cat < 28) begin
        x    = 0;
        frac = (frac == 0) ? 64'd1 : frac;
    end else if (cat == 28) begin
        x    = 0;
        frac = 64'd0;
    end else if (cat == 29) begin
        x    = emax + 1;
        frac = 64'd0;
    end else begin
        x          = emax + 1;
        frac[fw-1] = r[23];                    // quiet bit
        frac       = (frac == 0) ? 64'd1 : frac;
    end
    return dp ? {r[31], 11'(x), frac[51:0]} : {lcg_next(), r[31], 8'(x), frac[22:0]};
endfunction

`endif

// File: tb/tb_fpu_mul_top.sv
// testbench for the fp multiplier top level with random stimulus and a reference model
`default_nettype none

module tb_fpu_mul_top;

`include "fpu_model.svh"

    localparam int NUM_OPS      = 4000;
    localparam int MAX_GAP      = 3;
    localparam int RESET_CYCLES = 3;
    localparam int IDLE_CYCLES  = 2;
    localparam int LATENCY      = 3;
    localparam int QUIET_CYCLES = RESET_CYCLES + IDLE_CYCLES + LATENCY;
    localparam int MAX_CYCLES   = NUM_OPS * (1 + MAX_GAP) + QUIET_CYCLES + 50;

    typedef struct packed {
        logic [63:0]             res;
        logic [`FPU_FLAGS_W-1:0] flags;
        logic [63:0]             a;
        logic [63:0]             b;
        logic                    dp;
        logic [2:0]              rm;
        int                      cyc;   // cycle in which it was driven
    } exp_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    valid_i;
    logic                    fmt_i;
    logic [2:0]              rm_i;
    logic [63:0]             op_a_i;
    logic [63:0]             op_b_i;
    logic                    valid_o;
    logic [63:0]             result_o;
    logic [`FPU_FLAGS_W-1:0] flags_o;

    exp_t exp_q[$];
    int   cycle   = 0;
    int   errors  = 0;
    int   checked = 0;

    fpu_mul_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_i  (valid_i),
        .fmt_i    (fmt_i),
        .rm_i     (rm_i),
        .op_a_i   (op_a_i),
        .op_b_i   (op_b_i),
        .valid_o  (valid_o),
        .result_o (result_o),
        .flags_o  (flags_o)
    );

    always #4 clk = ~clk;

    task automatic finish_run();
        $display("%0d results checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    // drives one random operation and queues what the model expects
    task automatic issue_op();
        logic [31:0] r;
        logic [68:0] m;
        exp_t        e;
        r       = lcg_next();
        e.dp    = r[31];
        e.rm    = 3'(r[30:26] % 5);
        e.a     = gen_operand(e.dp);
        e.b     = gen_operand(e.dp);
        m       = model_mul(e.a, e.b, e.dp, e.rm);
        e.flags = m[68:64];
        e.res   = m[63:0];
        e.cyc   = cycle;
        valid_i = 1'b1;
        fmt_i   = e.dp;
        rm_i    = e.rm;
        op_a_i  = e.a;
        op_b_i  = e.b;
        exp_q.push_back(e);
    endtask

    task automatic check_result(input exp_t e);
        assert (result_o == e.res && flags_o == e.flags) else begin
            errors++;
            $display("Mismatch at time %0t: expected %h/%b got %h/%b, a %h b %h fmt %0d rm %0d",
                     $time, e.res, e.flags, result_o, flags_o, e.a, e.b, e.dp, e.rm);
        end
        assert (cycle == e.cyc + LATENCY) else begin
            errors++;
            $display("Mismatch at time %0t: result for a %h b %h in cycle %0d, expected %0d",
                     $time, e.a, e.b, cycle, e.cyc + LATENCY);
        end
        checked++;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            errors++;
            $display("timeout after %0d cycles with %0d results still outstanding",
                     cycle, exp_q.size());
            finish_run();
        end
    end

    // outputs sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (!rst_n || cycle < QUIET_CYCLES) begin
            assert (!valid_o && result_o == '0 && flags_o == '0) else begin
                errors++;
                $display("outputs not cleared during or right after reset at time %0t", $time);
            end
        end else if (valid_o) begin
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("valid_o high at time %0t with no operation in flight", $time);
            end
            if (exp_q.size() > 0) begin
                check_result(exp_q.pop_front());
            end
        end
    end

    initial begin
        logic [31:0] r;
        int          gap;
        rst_n   = 1'b0;
        valid_i = 1'b0;
        fmt_i   = 1'b0;
        rm_i    = 3'd0;
        op_a_i  = 64'h0;
        op_b_i  = 64'h0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk);
        #1;
        for (int i = 0; i < NUM_OPS; i++) begin
            issue_op();
            @(posedge clk);
            #1;
            r       = lcg_next();
            gap     = (r[31:30] == 2'b00) ? 1 + int'(r[29:28]) % MAX_GAP : 0;
            valid_i = 1'b0;
            op_a_i  = {r, ~r};   // junk while idle
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        // last result is due LATENCY cycles after it was driven
        repeat (LATENCY + 2) @(negedge clk);
        #1;
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected results never came out", exp_q.size());
        end
        finish_run();
    end

endmodule

`default_nettype wire
